// File: exu_config.svh
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// datapath and register index widths.
`define EXU_XLEN   32
`define EXU_REG_AW 5

// alu operation codes, 4 bits wide.
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLL  4'd2
`define ALU_SLT  4'd3
`define ALU_SLTU 4'd4
`define ALU_XOR  4'd5
`define ALU_SRL  4'd6
`define ALU_SRA  4'd7
`define ALU_OR   4'd8
`define ALU_AND  4'd9

// first operand choice. Code 3 is not named and selects zero as well.
`define OPA_RS1  2'd0
`define OPA_PC   2'd1
`define OPA_ZERO 2'd2

// second operand choice.
`define OPB_IMM  2'd0
`define OPB_RS2  2'd1
`define OPB_RDV  2'd2
`define OPB_ZERO 2'd3

`endif

// File: exu_pkg.sv
`include "exu_config.svh"

package exu_pkg;

    // a data word as it moves through the datapath.
    typedef logic [`EXU_XLEN-1:0] word_t;

    // an architectural register index.
    typedef logic [`EXU_REG_AW-1:0] reg_addr_t;

    // alu operation select, see the ALU_* codes.
    typedef logic [3:0] alu_op_t;

    // operand choice for either alu input.
    typedef logic [1:0] opnd_sel_t;

    // instruction sub-opcode, used for the branch condition and the memory size.
    typedef logic [2:0] funct3_t;

    // csr write enables. They only pass through this stage.
    typedef logic [3:0] csr_wen_t;

    // One decoded instruction as handed over by the decode stage.
    typedef struct packed {
        word_t     pc;         // address of the instruction.
        word_t     imm;        // immediate, already sign extended by decode.
        word_t     rs1_value;
        word_t     rs2_value;
        word_t     rd_value;   // old value of rd, an extra operand b source.
        reg_addr_t rd;
        funct3_t   funct3;
        alu_op_t   alu_op;
        opnd_sel_t a_sel;
        opnd_sel_t b_sel;
        logic      inv;        // flip bit 0 of the alu result.
        logic      branch;     // conditional branch.
        logic      jump;       // jal or jalr.
        logic      rf_wen;
        logic      mem_wen;
        logic      mem_ren;
        csr_wen_t  csr_wen;
    } exu_in_t;

    // The bundle handed on to the memory stage.
    typedef struct packed {
        word_t     pc;
        word_t     result;      // alu result, or the link address for a jump.
        word_t     store_data;  // rs2 value for stores.
        reg_addr_t rd;
        funct3_t   funct3;
        logic      rf_wen;
        logic      mem_wen;
        logic      mem_ren;
        csr_wen_t  csr_wen;
        logic      redirect;    // fetch must restart at redirect_pc.
        word_t     redirect_pc;
    } exu_out_t;

endpackage

// File: exu_stage_reg.sv
`timescale 1ns/1ps

// Holds the one instruction in flight through the execute stage.
// The stage is full while out_valid is high. It accepts a new instruction when
// it is empty, or in the same cycle that the memory stage takes the current one.
module exu_stage_reg (
    input  logic             clock,
    input  logic             reset,
    input  logic             flush,
    input  logic             in_valid,
    output logic             in_ready,
    input  exu_pkg::exu_in_t in_bundle,
    input  logic             out_ready,
    output logic             out_valid,
    output exu_pkg::exu_in_t held
);

    logic              valid_q;
    logic              accept;
    logic              take;
    exu_pkg::exu_in_t  payload_q;  // operands and decode fields.
    logic              branch_q;
    logic              jump_q;
    logic              rf_wen_q;
    logic              mem_wen_q;
    logic              mem_ren_q;
    exu_pkg::csr_wen_t csr_wen_q;

    assign in_ready = out_ready | ~valid_q;              // room now or after this edge.
    assign accept   = in_valid & in_ready & ~flush;
    assign take     = valid_q & out_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;                             // drop whatever is held.
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (take) begin
            valid_q <= 1'b0;
        end
    end

    // The enables are cleared so that a dropped instruction cannot write anything.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            branch_q  <= 1'b0;
            jump_q    <= 1'b0;
            rf_wen_q  <= 1'b0;
            mem_wen_q <= 1'b0;
            mem_ren_q <= 1'b0;
            csr_wen_q <= '0;
        end else if (flush) begin
            branch_q  <= 1'b0;
            jump_q    <= 1'b0;
            rf_wen_q  <= 1'b0;
            mem_wen_q <= 1'b0;
            mem_ren_q <= 1'b0;
            csr_wen_q <= '0;
        end else if (accept) begin
            branch_q  <= in_bundle.branch;
            jump_q    <= in_bundle.jump;
            rf_wen_q  <= in_bundle.rf_wen;
            mem_wen_q <= in_bundle.mem_wen;
            mem_ren_q <= in_bundle.mem_ren;
            csr_wen_q <= in_bundle.csr_wen;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            payload_q <= in_bundle;
        end
    end

    // The held view takes its enables from the cleared copies above.
    always_comb begin
        held         = payload_q;
        held.branch  = branch_q;
        held.jump    = jump_q;
        held.rf_wen  = rf_wen_q;
        held.mem_wen = mem_wen_q;
        held.mem_ren = mem_ren_q;
        held.csr_wen = csr_wen_q;
    end

    assign out_valid = valid_q;

endmodule

// File: alu_unit.sv
`timescale 1ns/1ps

`include "exu_config.svh"

// Operand selection and the integer ALU of the execute stage.
// The same adder also forms jump targets, since decode sets ADD for jal and jalr
// with the pc or rs1 as operand a and the immediate as operand b.
module alu_unit (
    input  exu_pkg::exu_in_t held,
    output exu_pkg::word_t   alu_result
);

    exu_pkg::word_t opnd_a;
    exu_pkg::word_t opnd_b;
    exu_pkg::word_t raw_result;
    logic [4:0]     shamt;
    logic           lt_signed;
    logic           lt_unsigned;

    // operand a: rs1, pc, or zero for lui style instructions.
    always_comb begin
        case (held.a_sel)
            `OPA_RS1:  opnd_a = held.rs1_value;
            `OPA_PC:   opnd_a = held.pc;
            `OPA_ZERO: opnd_a = '0;
            default:   opnd_a = '0;                      // code 3 is also zero.
        endcase
    end

    // operand b.
    always_comb begin
        case (held.b_sel)
            `OPB_IMM:  opnd_b = held.imm;
            `OPB_RS2:  opnd_b = held.rs2_value;
            `OPB_RDV:  opnd_b = held.rd_value;
            `OPB_ZERO: opnd_b = '0;
            default:   opnd_b = '0;
        endcase
    end

    assign shamt       = opnd_b[4:0];                    // only the low five bits shift.
    assign lt_signed   = $signed(opnd_a) < $signed(opnd_b);
    assign lt_unsigned = opnd_a < opnd_b;

    always_comb begin
        case (held.alu_op)
            `ALU_ADD:  raw_result = opnd_a + opnd_b;
            `ALU_SUB:  raw_result = opnd_a - opnd_b;
            `ALU_SLL:  raw_result = opnd_a << shamt;
            `ALU_SLT:  raw_result = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
            `ALU_SLTU: raw_result = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
            `ALU_XOR:  raw_result = opnd_a ^ opnd_b;
            `ALU_SRL:  raw_result = opnd_a >> shamt;
            `ALU_SRA:  raw_result = $signed(opnd_a) >>> shamt;
            `ALU_OR:   raw_result = opnd_a | opnd_b;
            `ALU_AND:  raw_result = opnd_a & opnd_b;
            default:   raw_result = '0;                  // codes 10 to 15 are unused.
        endcase
    end

    // The inversion turns slt into sge and similar, and applies to any operation.
    assign alu_result = raw_result ^ {{(`EXU_XLEN-1){1'b0}}, held.inv};

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps

// Branch condition and the two address adders of the execute stage.
// taken is the raw comparison; whether the instruction is a branch at all is
// decided in the merge block.
module branch_unit (
    input  exu_pkg::exu_in_t held,
    output logic             taken,
    output exu_pkg::word_t   link_pc,
    output exu_pkg::word_t   branch_target
);

    logic equal;
    logic less_signed;
    logic less_unsigned;

    assign equal         = held.rs1_value == held.rs2_value;
    assign less_signed   = $signed(held.rs1_value) < $signed(held.rs2_value);
    assign less_unsigned = held.rs1_value < held.rs2_value;

    // Condition by funct3, as in the base integer branch encoding.
    always_comb begin
        case (held.funct3)
            3'd0:    taken = equal;                      // beq.
            3'd1:    taken = ~equal;                     // bne.
            3'd4:    taken = less_signed;                // blt.
            3'd5:    taken = ~less_signed;               // bge.
            3'd6:    taken = less_unsigned;              // bltu.
            3'd7:    taken = ~less_unsigned;             // bgeu.
            default: taken = 1'b0;
        endcase
    end

    // The return address for jal and jalr.
    assign link_pc = held.pc + exu_pkg::word_t'(4);

    // The immediate already holds the scaled and sign extended offset.
    assign branch_target = held.pc + held.imm;

endmodule

// File: exu_merge.sv
`timescale 1ns/1ps

// Merges the ALU and branch results into the bundle for the memory stage.
module exu_merge (
    input  exu_pkg::exu_in_t  held,
    input  exu_pkg::word_t    alu_result,
    input  exu_pkg::word_t    link_pc,
    input  exu_pkg::word_t    branch_target,
    input  logic              taken,
    output exu_pkg::exu_out_t out_bundle
);

    logic           branch_taken;
    exu_pkg::word_t jump_target;
    exu_pkg::word_t redirect_pc;

    assign branch_taken = held.branch & taken;

    // jalr requires bit 0 of the target to be cleared; for jal it is already zero.
    assign jump_target = alu_result & ~exu_pkg::word_t'(1);

    always_comb begin
        if (held.jump) begin
            redirect_pc = jump_target;
        end else if (branch_taken) begin
            redirect_pc = branch_target;
        end else begin
            redirect_pc = '0;                            // no redirect.
        end
    end

    always_comb begin
        out_bundle.pc          = held.pc;
        out_bundle.result      = held.jump ? link_pc : alu_result;
        out_bundle.store_data  = held.rs2_value;
        out_bundle.rd          = held.rd;
        out_bundle.funct3      = held.funct3;            // the memory stage needs the size.
        out_bundle.rf_wen      = held.rf_wen;
        out_bundle.mem_wen     = held.mem_wen;
        out_bundle.mem_ren     = held.mem_ren;
        out_bundle.csr_wen     = held.csr_wen;
        out_bundle.redirect    = held.jump | branch_taken;
        out_bundle.redirect_pc = redirect_pc;
    end

endmodule

// File: exu_top.sv
`timescale 1ns/1ps

// Execute stage: the stage register followed by the ALU and branch logic.
// The output bundle is combinational from the stage register.
module exu_top (
    input  logic              clock,
    input  logic              reset,
    input  logic              flush,
    input  logic              in_valid,
    output logic              in_ready,
    input  exu_pkg::exu_in_t  in_bundle,
    output logic              out_valid,
    input  logic              out_ready,
    output exu_pkg::exu_out_t out_bundle
);

    exu_pkg::exu_in_t held;
    exu_pkg::word_t   alu_result;
    logic             taken;
    exu_pkg::word_t   link_pc;
    exu_pkg::word_t   branch_target;

    exu_stage_reg i_stage_reg (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_bundle (in_bundle),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .held      (held)
    );

    alu_unit i_alu (
        .held       (held),
        .alu_result (alu_result)
    );

    branch_unit i_branch (
        .held          (held),
        .taken         (taken),
        .link_pc       (link_pc),
        .branch_target (branch_target)
    );

    exu_merge i_merge (
        .held          (held),
        .alu_result    (alu_result),
        .link_pc       (link_pc),
        .branch_target (branch_target),
        .taken         (taken),
        .out_bundle    (out_bundle)
    );

endmodule

// File: exu_checker.sv
`timescale 1ns/1ps

`include "exu_config.svh"

// Watches the execute stage ports, predicts each output bundle from the accepted
// input and compares it with what the memory stage takes.
module exu_checker (
    input  logic              clock,
    input  logic              reset,
    input  logic              flush,
    input  logic              in_valid,
    input  logic              in_ready,
    input  exu_pkg::exu_in_t  in_bundle,
    input  logic              out_valid,
    input  logic              out_ready,
    input  exu_pkg::exu_out_t out_bundle,
    input  logic              end_of_test,
    output int                error_count,
    output int                checked_count
);

    exu_pkg::exu_out_t expected_q[$];   // one entry per accepted instruction.
    exu_pkg::exu_out_t last_bundle;
    logic              was_blocked = 1'b0;
    logic              was_accepted = 1'b0;
    int                errors = 0;
    int                checked = 0;

    assign error_count   = errors;
    assign checked_count = checked;

    // Reference model of the stage, written from the instruction set rules.
    function automatic exu_pkg::exu_out_t predict(input exu_pkg::exu_in_t b);
        exu_pkg::exu_out_t o;
        exu_pkg::word_t    a;
        exu_pkg::word_t    x;
        exu_pkg::word_t    r;
        logic              lt_s;
        logic              cond;
        case (b.a_sel)
            `OPA_RS1: a = b.rs1_value;
            `OPA_PC:  a = b.pc;
            default:  a = 32'd0;
        endcase
        case (b.b_sel)
            `OPB_IMM: x = b.imm;
            `OPB_RS2: x = b.rs2_value;
            `OPB_RDV: x = b.rd_value;
            default:  x = 32'd0;
        endcase
        case (b.alu_op)
            `ALU_ADD:  r = a + x;
            `ALU_SUB:  r = a + ~x + 32'd1;                  // two's complement subtract.
            `ALU_SLL:  r = a << x[4:0];
            `ALU_SLT:  r = {31'd0, (a[31] != x[31]) ? a[31] : (a < x)};
            `ALU_SLTU: r = {31'd0, a < x};
            `ALU_XOR:  r = a ^ x;
            `ALU_SRL:  r = a >> x[4:0];
            `ALU_SRA:  r = (a >> x[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> x[4:0]));
            `ALU_OR:   r = a | x;
            `ALU_AND:  r = a & x;
            default:   r = 32'd0;
        endcase
        r[0] = r[0] ^ b.inv;
        // A sign mismatch decides the signed order on its own.
        lt_s = (b.rs1_value[31] != b.rs2_value[31]) ? b.rs1_value[31]
                                                     : (b.rs1_value < b.rs2_value);
        case (b.funct3)
            3'd0:    cond = b.rs1_value == b.rs2_value;
            3'd1:    cond = b.rs1_value != b.rs2_value;
            3'd4:    cond = lt_s;
            3'd5:    cond = !lt_s;
            3'd6:    cond = b.rs1_value < b.rs2_value;
            3'd7:    cond = b.rs1_value >= b.rs2_value;
            default: cond = 1'b0;
        endcase
        cond          = cond & b.branch;
        o.pc          = b.pc;
        o.result      = b.jump ? b.pc + 32'd4 : r;
        o.store_data  = b.rs2_value;
        o.rd          = b.rd;
        o.funct3      = b.funct3;
        o.rf_wen      = b.rf_wen;
        o.mem_wen     = b.mem_wen;
        o.mem_ren     = b.mem_ren;
        o.csr_wen     = b.csr_wen;
        o.redirect    = b.jump | cond;
        o.redirect_pc = b.jump ? {r[31:1], 1'b0} : (cond ? b.pc + b.imm : 32'd0);
        return o;
    endfunction

    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("%s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_output(input exu_pkg::exu_out_t exp);
        check_field("pc", out_bundle.pc, exp.pc);
        check_field("result", out_bundle.result, exp.result);
        check_field("store_data", out_bundle.store_data, exp.store_data);
        check_field("rd", 32'(out_bundle.rd), 32'(exp.rd));
        check_field("funct3", 32'(out_bundle.funct3), 32'(exp.funct3));
        check_field("rf_wen", 32'(out_bundle.rf_wen), 32'(exp.rf_wen));
        check_field("mem_wen", 32'(out_bundle.mem_wen), 32'(exp.mem_wen));
        check_field("mem_ren", 32'(out_bundle.mem_ren), 32'(exp.mem_ren));
        check_field("csr_wen", 32'(out_bundle.csr_wen), 32'(exp.csr_wen));
        check_field("redirect", 32'(out_bundle.redirect), 32'(exp.redirect));
        check_field("redirect_pc", out_bundle.redirect_pc, exp.redirect_pc);
    endtask

    always @(posedge clock) begin
        if (reset) begin
            if (out_valid !== 1'b0) report_fail("out_valid is high during reset");
            if (in_ready !== 1'b1) report_fail("in_ready is low during reset");
            if ({out_bundle.rf_wen, out_bundle.mem_wen, out_bundle.mem_ren,
                 out_bundle.csr_wen, out_bundle.redirect} !== 8'd0) begin
                report_fail("write enables are not cleared by reset");
            end
            expected_q.delete();
            was_blocked  = 1'b0;
            was_accepted = 1'b0;
        end else begin
            // an accepted instruction is presented exactly one edge later.
            if (was_accepted && !out_valid) begin
                report_fail("out_valid is low one cycle after an accepted input");
            end
            // a stalled output must still be there, and unchanged.
            if (was_blocked && !out_valid) begin
                $display("held output disappeared without being taken at %0t ns", $time);
                errors++;
            end else if (was_blocked && out_bundle !== last_bundle) begin
                report_fail("output bundle changed while the memory stage stalled");
            end
            if (out_valid && !out_ready && in_ready) begin
                report_fail("in_ready is high while the stage is full and stalled");
            end
            if (!out_valid && !in_ready) report_fail("in_ready is low while the stage is empty");
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("unexpected output at %0t ns with no instruction accepted for it",
                             $time);
                    errors++;
                end else begin
                    compare_output(expected_q.pop_front());
                    checked++;
                end
            end
            if (flush) begin
                expected_q.delete();                        // the held instruction is dropped.
            end else if (in_valid && in_ready) begin
                expected_q.push_back(predict(in_bundle));
            end
            was_blocked  = out_valid && !out_ready && !flush;
            was_accepted = in_valid && in_ready && !flush;
            last_bundle  = out_bundle;
            if (end_of_test && expected_q.size() != 0) begin
                $display("%0d accepted instructions were lost, never reaching the output",
                         expected_q.size());
                errors++;
                expected_q.delete();
            end
        end
    end

endmodule

// File: tb_exu.sv
`timescale 1ns/1ps

`include "exu_config.svh"

module tb_exu;

    localparam int CLOCK_PERIOD    = 100;
    localparam int NUM_TESTS       = 6;
    localparam int TXN_PER_TEST    = 200;
    localparam int EXPECTED_CYCLES = NUM_TESTS * TXN_PER_TEST * 2;  // stalls about double it.
    localparam int TIMEOUT_CYCLES  = 5 * EXPECTED_CYCLES;

    logic              clock = 1'b0;
    logic              reset;
    logic              flush;
    logic              in_valid;
    logic              in_ready;
    exu_pkg::exu_in_t  in_bundle;
    logic              out_valid;
    logic              out_ready;
    exu_pkg::exu_out_t out_bundle;
    logic              end_of_test;
    int                error_count;
    int                checked_count;
    int                cycle_count = 0;
    int                clean_tests = 0;
    logic [31:0]       rand_state = 32'd11;

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    exu_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle)
    );

    exu_checker i_checker (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_bundle     (in_bundle),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_bundle    (out_bundle),
        .end_of_test   (end_of_test),
        .error_count   (error_count),
        .checked_count (checked_count)
    );

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // linear congruential generator; the upper half has the better bits.
    function automatic logic [15:0] next_random16();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state[31:16];
    endfunction

    function automatic logic [31:0] next_random();
        logic [15:0] hi;
        hi = next_random16();
        return {hi, next_random16()};
    endfunction

    task automatic make_bundle(input int test_id, output exu_pkg::exu_in_t b);
        logic [31:0] r;
        b.pc        = next_random() & 32'hffff_fffc;
        b.imm       = next_random();
        b.rs1_value = next_random();
        b.rs2_value = next_random();
        b.rd_value  = next_random();
        r           = next_random();
        b.rd        = r[4:0];
        b.funct3    = r[7:5];
        b.a_sel     = r[9:8];
        b.b_sel     = r[11:10];
        b.rf_wen    = r[12];
        b.mem_wen   = r[13];
        b.mem_ren   = r[14];
        b.csr_wen   = r[18:15];
        b.alu_op    = exu_pkg::alu_op_t'(r[31:19] % 13'd10);
        b.inv       = 1'b0;
        b.branch    = 1'b0;
        b.jump      = 1'b0;
        case (test_id)
            3: begin
                b.inv = 1'b1;
                if (r[19]) b.alu_op = r[20] ? `ALU_SLT : `ALU_SLTU;
            end
            4: begin
                b.branch = 1'b1;
                if (next_random() % 32'd3 == 32'd0) b.rs2_value = b.rs1_value;
            end
            5: begin
                b.jump   = 1'b1;                            // jal with pc, jalr with rs1.
                b.alu_op = `ALU_ADD;
                b.a_sel  = r[8] ? `OPA_PC : `OPA_RS1;
                b.b_sel  = `OPB_IMM;
            end
            6: begin
                b.inv    = r[21];
                b.branch = r[22];
                b.jump   = r[23] & r[24];
            end
            default: ;
        endcase
    endtask

    // Offers one instruction until the stage accepts it; stress adds stalls and flushes.
    task automatic send(input exu_pkg::exu_in_t b, input bit stress);
        logic [15:0] r;
        bit          accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clock);
            r         = next_random16();
            in_bundle = b;
            in_valid  = stress ? (r[5:4] != 2'd0) : 1'b1;
            out_ready = stress ? r[0] : 1'b1;
            flush     = stress ? (r[3:1] == 3'd0) : 1'b0;
            #(CLOCK_PERIOD / 4);
            accepted  = in_valid & in_ready & ~flush;
            @(posedge clock);
        end
    endtask

    task automatic run_test(input int test_id, input string name);
        exu_pkg::exu_in_t b;
        int               errors_before;
        int               checked_before;
        int               n;
        errors_before  = error_count;
        checked_before = checked_count;
        if (test_id == 1) begin
            repeat (8) @(negedge clock);                    // reset held for eight cycles.
            reset = 1'b0;
            repeat (4) @(negedge clock);                    // idle right after reset.
        end else begin
            for (n = 0; n < TXN_PER_TEST; n++) begin
                make_bundle(test_id, b);
                send(b, test_id == 6);
            end
        end
        @(negedge clock);
        in_valid  = 1'b0;
        flush     = 1'b0;
        out_ready = 1'b1;
        while (out_valid) @(negedge clock);
        end_of_test = 1'b1;
        @(negedge clock);
        end_of_test = 1'b0;
        if (error_count == errors_before) begin
            clean_tests++;
            $display("test %0d %s: ok, %0d outputs checked", test_id, name,
                     checked_count - checked_before);
        end else begin
            $display("test %0d %s: %0d errors", test_id, name, error_count - errors_before);
        end
    endtask

    initial begin
        reset       = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_bundle   = '0;
        out_ready   = 1'b0;
        end_of_test = 1'b0;
        run_test(1, "reset state");
        run_test(2, "alu operations");
        run_test(3, "inverted results");
        run_test(4, "branches");
        run_test(5, "jumps");
        run_test(6, "back-pressure and flush");
        $display("summary: %0d of %0d tests clean, %0d outputs checked, %0d errors",
                 clean_tests, NUM_TESTS, checked_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: exu_top.f
+incdir+.
exu_pkg.sv
exu_stage_reg.sv
alu_unit.sv
branch_unit.sv
exu_merge.sv
exu_top.sv
exu_checker.sv
tb_exu.sv

// File: run.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary -f exu_top.f --top-module tb_exu -o tb_exu_sim

output=$(./obj_dir/tb_exu_sim)
echo "$output"

if echo "$output" | grep -qx "all tests passed"; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail"
exit 1
